// File: video_capture.f
verilog/frame_pkg.sv
verilog/frame_memory.sv
verilog/frame_capture.sv
verilog/grayscale_copy.sv
verilog/udp_readout.sv
verilog/video_capture_top.sv
test/tb_video_source.sv
test/tb_video_capture.sv

// File: Makefile
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_video_capture \
		-f video_capture.f -Mdir obj_dir -o tb_video_capture
	./obj_dir/tb_video_capture

clean:
	rm -rf obj_dir

// File: test/tb_video_capture.sv
`timescale 1ns/1ps
`default_nettype none

module tb_video_capture;
    import frame_pkg::*;

    localparam int FRAME_WIDTH  = 16;
    localparam int FRAME_HEIGHT = 8;
    localparam int FRAME_PIXELS = FRAME_WIDTH * FRAME_HEIGHT;
    localparam int DEPTH        = 2 * FRAME_PIXELS;
    localparam int TIMEOUT      = 2000;

    logic        clk;
    logic        reset_i;
    logic        arm;
    video_t      video;
    udp_word_t   rx;
    udp_word_t   tx;
    logic        done;
    int          done_count;
    pixel_t      model [DEPTH];
    logic [31:0] got_q [$];

    video_capture_top #(
        .FRAME_WIDTH (FRAME_WIDTH),
        .FRAME_HEIGHT(FRAME_HEIGHT)
    ) i_dut (
        .clk    (clk),
        .reset_i(reset_i),
        .video_i(video),
        .rx_i   (rx),
        .tx_o   (tx),
        .done_o (done)
    );

    tb_video_source #(
        .FRAME_WIDTH (FRAME_WIDTH),
        .FRAME_HEIGHT(FRAME_HEIGHT)
    ) i_src (
        .clk    (clk),
        .arm_i  (arm),
        .video_o(video)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        if (done) begin
            done_count <= done_count + 1;
        end
    end

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Test failures found");
        $fatal(1, "stopped at first error");
    endtask

    // Luma with weights scaled by 256 and copied to all channels
    function automatic pixel_t gray_of(input pixel_t p);
        int y;
        y = (GRAY_R_WEIGHT * p.r + GRAY_G_WEIGHT * p.g + GRAY_B_WEIGHT * p.b) >> 8;
        return {y[7:0], y[7:0], y[7:0]};
    endfunction

    task automatic send_cmd(input opcode_e op, input int count, input int addr);
        logic [31:0] w;
        w = '0;
        w[CMD_OP_LSB +: 4]     = op;
        w[CMD_COUNT_LSB +: 12] = count[11:0];
        w[CMD_ADDR_LSB +: 16]  = addr[15:0];
        @(posedge clk);
        rx.enable <= 1'b1;
        rx.data   <= w;
        @(posedge clk);
        rx <= '0;
    endtask

    task automatic wait_done(input int pulses);
        int cycles;
        cycles = 0;
        while (done_count < pulses) begin
            @(posedge clk);
            cycles++;
            if (cycles > TIMEOUT) begin
                fail_run("timeout waiting for done_o");
            end
        end
    endtask

    // Extra words show up in the quiet window after the last one
    task automatic read_check(input int addr, input int count);
        int cycles;
        int a;
        got_q.delete();
        send_cmd(OP_READ, count, addr);
        cycles = 0;
        while (got_q.size() < count) begin
            @(posedge clk);
            if (tx.enable) begin
                got_q.push_back(tx.data);
            end
            cycles++;
            if (cycles > TIMEOUT) begin
                fail_run("timeout waiting for tx_o words");
            end
        end
        for (int i = 0; i < 50; i++) begin
            @(posedge clk);
            if (tx.enable) begin
                got_q.push_back(tx.data);
            end
        end
        assert (got_q.size() == count) else fail_run($sformatf(
            "mismatch tx_o word count: got %h expected %h", got_q.size(), count));
        for (int i = 0; i < count; i++) begin
            a = (addr + i) % DEPTH;
            assert (got_q[i] == {8'h00, model[a]}) else fail_run($sformatf(
                "mismatch tx_o.data at address %h: got %h expected %h",
                a, got_q[i], {8'h00, model[a]}));
        end
    endtask

    initial begin
        int cycles;
        void'($urandom(7666));
        reset_i    = 1'b1;
        arm        = 1'b0;
        rx         = '0;
        done_count = 0;
        repeat (8) @(posedge clk);
        reset_i <= 1'b0;

        for (int i = 0; i < 5; i++) begin
            @(posedge clk);
            assert (!tx.enable && !done) else fail_run(
                "tx_o.enable or done_o went high before any command");
        end

        // Capture is sent while the source still sends junk pixels
        send_cmd(OP_CAPTURE, 0, 0);
        arm <= 1'b1;
        cycles = 0;
        while (!i_dut.copy_busy) begin
            @(posedge clk);
            cycles++;
            if (cycles > TIMEOUT) begin
                fail_run("timeout waiting for the gray copy to start");
            end
        end
        send_cmd(OP_CAPTURE, 0, 0);
        wait_done(1);
        // Long enough for a second frame and copy to finish
        repeat (400) @(posedge clk);
        assert (done_count == 1) else fail_run($sformatf(
            "mismatch done_o pulse count: got %h expected %h", done_count, 1));
        assert (i_src.recorded) else fail_run("video source recorded no frame");

        for (int i = 0; i < FRAME_PIXELS; i++) begin
            model[i]                = i_src.frame[i];
            model[i + FRAME_PIXELS] = gray_of(i_src.frame[i]);
        end
        read_check(0, FRAME_PIXELS);
        read_check(FRAME_PIXELS, FRAME_PIXELS);
        for (int n = 0; n < 4; n++) begin
            read_check($urandom % DEPTH, 1 + $urandom % 400);
        end
        read_check($urandom % DEPTH, 0);

        $display("All tests passed!");
        $finish;
    end

endmodule

`default_nettype wire

// File: test/tb_video_source.sv
`timescale 1ns/1ps
`default_nettype none

module tb_video_source #(
    parameter int FRAME_WIDTH  = 16,
    parameter int FRAME_HEIGHT = 8
) (
    input  wire logic         clk,
    input  wire logic         arm_i,
    output frame_pkg::video_t video_o
);
    import frame_pkg::*;

    localparam int FRAME_PIXELS = FRAME_WIDTH * FRAME_HEIGHT;

    // Expected raw frame in raster order
    pixel_t frame [FRAME_PIXELS];
    logic   recorded;

    function automatic pixel_t random_pixel();
        logic [31:0] r;
        r = $urandom;
        return r[23:0];
    endfunction

    task automatic drive(input logic vs, input logic de, input int n);
        video_t v;
        for (int i = 0; i < n; i++) begin
            @(posedge clk);
            v.vsync = vs;
            v.de    = de;
            v.pixel = de ? random_pixel() : '0;
            video_o <= v;
        end
    endtask

    initial begin
        logic   keep;
        video_t v;
        video_o  = '0;
        recorded = 1'b0;
        // Active pixels with no frame start in front of them
        drive(1'b0, 1'b1, 30);
        forever begin
            // Arm is sampled on the edge where vsync goes high
            @(posedge clk);
            keep = arm_i && !recorded;
            video_o <= '0;
            video_o.vsync <= 1'b1;
            drive(1'b1, 1'b0, 2);
            drive(1'b0, 1'b0, 4);
            for (int y = 0; y < FRAME_HEIGHT; y++) begin
                for (int x = 0; x < FRAME_WIDTH; x++) begin
                    @(posedge clk);
                    v.vsync = 1'b0;
                    v.de    = 1'b1;
                    v.pixel = random_pixel();
                    video_o <= v;
                    if (keep) begin
                        frame[y * FRAME_WIDTH + x] = v.pixel;
                    end
                end
                drive(1'b0, 1'b0, 3);
            end
            drive(1'b0, 1'b0, 5);
            if (keep) begin
                recorded = 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/video_capture_top.sv
`timescale 1ns/1ps
`default_nettype none

module video_capture_top #(
    parameter int FRAME_WIDTH  = 16,
    parameter int FRAME_HEIGHT = 8
) (
    input  wire logic                 clk,
    input  wire logic                 reset_i,
    input  wire frame_pkg::video_t    video_i,
    input  wire frame_pkg::udp_word_t rx_i,
    output frame_pkg::udp_word_t      tx_o,
    output logic                      done_o
);
    import frame_pkg::*;

    localparam int FRAME_PIXELS = FRAME_WIDTH * FRAME_HEIGHT;

    mem_wr_t cap_wr;
    mem_wr_t copy_wr;
    mem_rd_t copy_rd;
    mem_rd_t out_rd;
    logic    copy_grant;
    logic    out_grant;
    pixel_t  rd_data;
    logic    cap_start;
    logic    cap_done;
    logic    copy_busy;

    frame_memory #(
        .FRAME_PIXELS(FRAME_PIXELS)
    ) u_frame_memory (
        .clk         (clk),
        .reset_i     (reset_i),
        .cap_wr_i    (cap_wr),
        .copy_wr_i   (copy_wr),
        .copy_rd_i   (copy_rd),
        .out_rd_i    (out_rd),
        .copy_grant_o(copy_grant),
        .out_grant_o (out_grant),
        .rd_data_o   (rd_data)
    );

    frame_capture #(
        .FRAME_PIXELS(FRAME_PIXELS)
    ) u_frame_capture (
        .clk        (clk),
        .reset_i    (reset_i),
        .video_i    (video_i),
        .start_i    (cap_start),
        .copy_busy_i(copy_busy),
        .wr_o       (cap_wr),
        .done_o     (cap_done)
    );

    // Gray pass kicks off when the raw frame is complete
    grayscale_copy #(
        .FRAME_PIXELS(FRAME_PIXELS)
    ) u_grayscale_copy (
        .clk      (clk),
        .reset_i  (reset_i),
        .start_i  (cap_done),
        .grant_i  (copy_grant),
        .rd_data_i(rd_data),
        .rd_o     (copy_rd),
        .wr_o     (copy_wr),
        .busy_o   (copy_busy),
        .done_o   (done_o)
    );

    udp_readout #(
        .FRAME_PIXELS(FRAME_PIXELS)
    ) u_udp_readout (
        .clk      (clk),
        .reset_i  (reset_i),
        .rx_i     (rx_i),
        .grant_i  (out_grant),
        .rd_data_i(rd_data),
        .rd_o     (out_rd),
        .capture_o(cap_start),
        .tx_o     (tx_o)
    );

endmodule

`default_nettype wire

// File: verilog/udp_readout.sv
`timescale 1ns/1ps
`default_nettype none

module udp_readout #(
    parameter int FRAME_PIXELS = 128
) (
    input  wire logic                 clk,
    input  wire logic                 reset_i,
    input  wire frame_pkg::udp_word_t rx_i,
    input  wire logic                 grant_i,
    input  wire frame_pkg::pixel_t    rd_data_i,
    output frame_pkg::mem_rd_t        rd_o,
    output logic                      capture_o,
    output frame_pkg::udp_word_t      tx_o
);
    import frame_pkg::*;

    localparam int        DEPTH     = 2 * FRAME_PIXELS;
    localparam mem_addr_t ADDR_LAST = mem_addr_t'(DEPTH - 1);

    opcode_e     cmd_op;
    logic [11:0] cmd_count;
    mem_addr_t   cmd_addr;
    logic        cmd_ok;
    logic        cmd_read;
    logic        active;
    logic        rd_fire;
    logic        pending;
    mem_addr_t   rd_addr;
    logic [11:0] remain;

    assign cmd_op    = opcode_e'(rx_i.data[CMD_OP_LSB +: 4]);
    assign cmd_count = rx_i.data[CMD_COUNT_LSB +: 12];
    assign cmd_addr  = rx_i.data[CMD_ADDR_LSB +: 16];

    // Anything arriving mid-read is dropped
    assign cmd_ok   = rx_i.enable & ~active;
    assign cmd_read = cmd_ok && (cmd_op == OP_READ);
    assign rd_fire  = active & grant_i;

    always_comb begin
        rd_o.en   = active;
        rd_o.addr = rd_addr;
    end

    // Memory word lands one cycle after the grant
    always_comb begin
        tx_o.enable = pending;
        tx_o.data   = {8'h00, rd_data_i};
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            active    <= 1'b0;
            pending   <= 1'b0;
            capture_o <= 1'b0;
        end else begin
            capture_o <= cmd_ok && (cmd_op == OP_CAPTURE);
            pending   <= rd_fire;
            // Zero count never starts a read
            if (cmd_read && cmd_count != '0) begin
                active <= 1'b1;
            end else if (rd_fire && remain == 12'd1) begin
                active <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (cmd_read) begin
            rd_addr <= mem_addr_t'(32'(cmd_addr) % DEPTH);
            remain  <= cmd_count;
        end else if (rd_fire) begin
            rd_addr <= (rd_addr == ADDR_LAST) ? '0 : rd_addr + 1'b1;
            remain  <= remain - 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: verilog/grayscale_copy.sv
`timescale 1ns/1ps
`default_nettype none

module grayscale_copy #(
    parameter int FRAME_PIXELS = 128
) (
    input  wire logic              clk,
    input  wire logic              reset_i,
    input  wire logic              start_i,
    input  wire logic              grant_i,
    input  wire frame_pkg::pixel_t rd_data_i,
    output frame_pkg::mem_rd_t     rd_o,
    output frame_pkg::mem_wr_t     wr_o,
    output logic                   busy_o,
    output logic                   done_o
);
    import frame_pkg::*;

    localparam mem_addr_t RD_LAST = mem_addr_t'(FRAME_PIXELS - 1);
    localparam mem_addr_t WR_LAST = mem_addr_t'(2 * FRAME_PIXELS - 1);

    logic        reading;
    logic        busy_q;
    logic        kick;
    logic        rd_fire;
    mem_addr_t   rd_cnt;
    logic        s1_valid;
    logic        s2_valid;
    mem_addr_t   s1_addr;
    mem_addr_t   s2_addr;
    logic        wr_last;
    logic [15:0] gray_sum;
    logic [7:0]  gray_q;

    assign kick    = start_i & ~busy_q;
    assign rd_fire = reading & grant_i;
    assign wr_last = s2_valid && (s2_addr == WR_LAST);

    // Busy already in the start cycle, so a capture cannot slip in
    assign busy_o = busy_q | start_i;

    always_comb begin
        rd_o.en   = reading;
        rd_o.addr = rd_cnt;
    end

    // Weighted luma sum with the top byte kept
    assign gray_sum = 16'(GRAY_R_WEIGHT * rd_data_i.r
                        + GRAY_G_WEIGHT * rd_data_i.g
                        + GRAY_B_WEIGHT * rd_data_i.b);

    always_comb begin
        wr_o.en   = s2_valid;
        wr_o.addr = s2_addr;
        wr_o.data = {gray_q, gray_q, gray_q};
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            reading  <= 1'b0;
            busy_q   <= 1'b0;
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
            done_o   <= 1'b0;
        end else begin
            if (kick) begin
                reading <= 1'b1;
                busy_q  <= 1'b1;
            end else begin
                if (rd_fire && rd_cnt == RD_LAST) begin
                    reading <= 1'b0;
                end
                if (wr_last) begin
                    busy_q <= 1'b0;
                end
            end
            // s1 marks the cycle the read data is valid
            s1_valid <= rd_fire;
            s2_valid <= s1_valid;
            done_o   <= wr_last;
        end
    end

    always_ff @(posedge clk) begin
        if (kick) begin
            rd_cnt <= '0;
        end else if (rd_fire) begin
            rd_cnt <= rd_cnt + 1'b1;
        end
        s1_addr <= rd_cnt + mem_addr_t'(FRAME_PIXELS);
        s2_addr <= s1_addr;
        gray_q  <= gray_sum[15:8];
    end

endmodule

`default_nettype wire

// File: verilog/frame_capture.sv
`timescale 1ns/1ps
`default_nettype none

module frame_capture #(
    parameter int FRAME_PIXELS = 128
) (
    input  wire logic              clk,
    input  wire logic              reset_i,
    input  wire frame_pkg::video_t video_i,
    input  wire logic              start_i,
    input  wire logic              copy_busy_i,
    output frame_pkg::mem_wr_t     wr_o,
    output logic                   done_o
);
    import frame_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        WAIT_FRAME,
        STORE
    } state_e;

    state_e    state;
    logic      vsync_q;
    logic      vsync_rise;
    mem_addr_t pix_cnt;
    logic      last_pix;

    assign vsync_rise = video_i.vsync & ~vsync_q;
    assign last_pix   = pix_cnt == mem_addr_t'(FRAME_PIXELS - 1);

    // Raw region starts at 0, so the count is the address
    always_comb begin
        wr_o.en   = (state == STORE) && video_i.de;
        wr_o.addr = pix_cnt;
        wr_o.data = video_i.pixel;
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state   <= IDLE;
            vsync_q <= 1'b0;
            done_o  <= 1'b0;
        end else begin
            vsync_q <= video_i.vsync;
            done_o  <= 1'b0;
            case (state)
                IDLE: begin
                    // Raw region is still being read by the copy
                    if (start_i && !copy_busy_i) begin
                        state <= WAIT_FRAME;
                    end
                end
                WAIT_FRAME: begin
                    if (vsync_rise) begin
                        state <= STORE;
                    end
                end
                STORE: begin
                    if (video_i.de && last_pix) begin
                        state  <= IDLE;
                        done_o <= 1'b1;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == WAIT_FRAME) begin
            pix_cnt <= '0;
        end else if (wr_o.en) begin
            pix_cnt <= pix_cnt + 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: verilog/frame_memory.sv
`timescale 1ns/1ps
`default_nettype none

module frame_memory #(
    parameter int FRAME_PIXELS = 128
) (
    input  wire logic               clk,
    input  wire logic               reset_i,
    input  wire frame_pkg::mem_wr_t cap_wr_i,
    input  wire frame_pkg::mem_wr_t copy_wr_i,
    input  wire frame_pkg::mem_rd_t copy_rd_i,
    input  wire frame_pkg::mem_rd_t out_rd_i,
    output logic                    copy_grant_o,
    output logic                    out_grant_o,
    output frame_pkg::pixel_t       rd_data_o
);
    import frame_pkg::*;

    // Raw region at 0 and gray region at FRAME_PIXELS
    localparam int DEPTH  = 2 * FRAME_PIXELS;
    localparam int ADDR_W = $clog2(DEPTH);

    pixel_t    mem [DEPTH];
    mem_wr_t   wr_sel;
    logic      wr_en;
    mem_addr_t rd_addr;
    logic      rd_en;

    // Capture write takes the port if both ever show up
    assign wr_sel = cap_wr_i.en ? cap_wr_i : copy_wr_i;

    // No writes land while reset is held
    assign wr_en = wr_sel.en & ~reset_i;

    // Copy read has priority over the readout
    assign copy_grant_o = copy_rd_i.en;
    assign out_grant_o  = out_rd_i.en & ~copy_rd_i.en;

    assign rd_en   = copy_rd_i.en | out_rd_i.en;
    assign rd_addr = copy_rd_i.en ? copy_rd_i.addr : out_rd_i.addr;

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_sel.addr[ADDR_W-1:0]] <= wr_sel.data;
        end
    end

    // Data shows up one cycle after the grant for both readers
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data_o <= mem[rd_addr[ADDR_W-1:0]];
        end
    end

endmodule

`default_nettype wire

// File: verilog/frame_pkg.sv
`default_nettype none

package frame_pkg;

    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } pixel_t;

    typedef struct packed {
        logic   vsync;
        logic   de;
        pixel_t pixel;
    } video_t;

    typedef logic [15:0] mem_addr_t;

    typedef struct packed {
        logic      en;
        mem_addr_t addr;
        pixel_t    data;
    } mem_wr_t;

    typedef struct packed {
        logic      en;
        mem_addr_t addr;
    } mem_rd_t;

    typedef enum logic [3:0] {
        OP_CAPTURE = 4'd1,
        OP_READ    = 4'd2
    } opcode_e;

    // Shared by the command and the response stream
    typedef struct packed {
        logic        enable;
        logic [31:0] data;
    } udp_word_t;

    // Opcode in [31:28], count in [27:16] and start address in [15:0]
    localparam int CMD_OP_LSB    = 28;
    localparam int CMD_COUNT_LSB = 16;
    localparam int CMD_ADDR_LSB  = 0;

    // Luma weights scaled by 256
    localparam int GRAY_R_WEIGHT = 77;
    localparam int GRAY_G_WEIGHT = 150;
    localparam int GRAY_B_WEIGHT = 29;

endpackage

`default_nettype wire
